//--- dcache.f
+incdir+source
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache.sv
tests/tb_clock.sv
tests/dcache_scoreboard.sv
tests/dcache_chk.sv
tests/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wall -f dcache.f --top-module tb_dcache \
    -o sim_dcache > build.log 2>&1 \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int N_OPS = 800;
    // worst case per op is a writeback plus a refill with long waits
    localparam int LIMIT = N_OPS * 40 + 200;
    // two requests in flight, at most one of them a dirty miss
    localparam int DRAIN_MAX = 100;

    logic              clk_g;
    logic              resetn;
    logic              req;
    logic              wr;
    dcache_pkg::addr_t addr;
    dcache_pkg::strb_t wstrb;
    dcache_pkg::word_t wdata;
    logic              addr_ok;
    logic              data_ok;
    dcache_pkg::word_t rdata;
    logic              rd_req;
    dcache_pkg::addr_t rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    dcache_pkg::line_t ret_data;
    logic              wr_req;
    dcache_pkg::addr_t wr_addr;
    dcache_pkg::line_t wr_data;
    logic              wr_rdy;
    logic              wr_bvalid;

    integer      seed = 32'hc9be_c7e8;
    int          cycles = 0;
    int          refills;
    int          errs_before;
    logic [31:0] mem [logic [29:0]];

    tb_clock u_clock (.clk_g(clk_g), .resetn(resetn));

    dcache dut (.*);

    dcache_scoreboard sb (.*);

    bind dcache_ctrl dcache_chk u_chk (.*);

    function automatic logic [31:0] mem_word(input logic [29:0] wa);
        return mem.exists(wa) ? mem[wa] : ({2'b00, wa} ^ 32'h5a5a_0000);
    endfunction

    // random word aligned address in a 2 KB window
    function automatic logic [31:0] rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return {21'h0, r[10:2], 2'b00};
    endfunction

    // memory model that sees requests at negedge and answers on posedges
    always begin
        logic [31:0] a;
        int          d0;
        int          d1;
        @(negedge clk_g);
        d0 = {$random(seed)} % 6;
        d1 = {$random(seed)} % 6;
        if (resetn && rd_req) begin
            a = rd_addr;
            @(posedge clk_g);
            repeat (d0) @(posedge clk_g);
            rd_rdy <= 1'b1;
            @(posedge clk_g);
            rd_rdy <= 1'b0;
            repeat (d1) @(posedge clk_g);
            for (int i = 0; i < 4; i++) begin
                ret_data[i*32 +: 32] <= mem_word({a[31:4], 2'(i)});
            end
            ret_valid <= 1'b1;
            @(posedge clk_g);
            ret_valid <= 1'b0;
        end else if (resetn && wr_req) begin
            a = wr_addr;
            for (int i = 0; i < 4; i++) begin
                mem[{a[31:4], 2'(i)}] = wr_data[i*32 +: 32];
            end
            @(posedge clk_g);
            repeat (d0) @(posedge clk_g);
            wr_rdy <= 1'b1;
            @(posedge clk_g);
            wr_rdy <= 1'b0;
            repeat (d1) @(posedge clk_g);
            wr_bvalid <= 1'b1;
            @(posedge clk_g);
            wr_bvalid <= 1'b0;
        end
    end

    // starts on a rising edge and returns on the edge that accepts
    task automatic issue(input logic is_wr, input logic [31:0] a,
                         input logic [3:0] s, input logic [31:0] d);
        req   <= 1'b1;
        wr    <= is_wr;
        addr  <= a;
        wstrb <= is_wr ? s : 4'h0;
        wdata <= d;
        @(negedge clk_g);
        while (!addr_ok) @(negedge clk_g);
        @(posedge clk_g);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        req <= 1'b0;
        wr  <= 1'b0;
        @(negedge clk_g);
        while (sb.n_acc != sb.n_done && waited < DRAIN_MAX) begin
            @(negedge clk_g);
            waited++;
        end
        @(posedge clk_g);
    endtask

    task automatic finish_test();
        drain();
        $display("test %s done, errors %0d", sb.test_name, sb.n_errors - errs_before);
        errs_before = sb.n_errors;
    endtask

    task automatic check_refills(input int expected);
        if (sb.n_refill - refills != expected) begin
            $display("[FAIL] %s: expected %0d actual %0d refills",
                sb.test_name, expected, sb.n_refill - refills);
            sb.n_errors++;
        end
        refills = sb.n_refill;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] s;
        req       = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wr_bvalid = 1'b0;
        errs_before = 0;
        @(posedge clk_g);
        while (!resetn) @(posedge clk_g);

        // power-up content on first loads
        for (int i = 0; i < 8; i++) issue(1'b0, rand_addr(), 4'h0, 32'h0);
        finish_test();

        // store then load the same word back to back
        sb.test_name = "store_load_fwd";
        for (int i = 0; i < 20; i++) begin
            a = rand_addr();
            s = $random(seed);
            issue(1'b1, a, s[3:0], $random(seed));
            issue(1'b0, a, 4'h0, 32'h0);
        end
        finish_test();

        // five tags into one set are stored then read back after eviction
        sb.test_name = "conflict_evict";
        for (int k = 0; k < 3; k++) begin
            s = $random(seed);
            for (int t = 0; t < 5; t++) begin
                issue(1'b1, {21'h0, 3'(t), s[3:0], 4'h4}, 4'hf, $random(seed));
            end
            for (int t = 0; t < 5; t++) begin
                issue(1'b0, {21'h0, 3'(t), s[3:0], 4'h4}, 4'h0, 32'h0);
            end
        end
        finish_test();

        // in set 9 tag 1 is made recent so tag 2 is the victim of tag 3
        sb.test_name = "lru_order";
        issue(1'b0, 32'h0000_0190, 4'h0, 32'h0);
        issue(1'b0, 32'h0000_0290, 4'h0, 32'h0);
        issue(1'b0, 32'h0000_0190, 4'h0, 32'h0);
        issue(1'b0, 32'h0000_0198, 4'h0, 32'h0);
        drain();
        refills = sb.n_refill;
        issue(1'b0, 32'h0000_0390, 4'h0, 32'h0);
        drain();
        check_refills(1);
        issue(1'b0, 32'h0000_0194, 4'h0, 32'h0);
        drain();
        check_refills(0);
        finish_test();

        sb.test_name = "random_mix";
        for (int i = 0; i < 600; i++) begin
            s = $random(seed);
            if (s[5:4] == 2'b00) begin
                drain();
            end
            issue(s[0], rand_addr(), s[11:8], $random(seed));
        end
        finish_test();

        if (sb.n_acc != sb.n_done) begin
            $display("[FAIL] completion_count: expected %0d actual %0d completions",
                sb.n_acc, sb.n_done);
            sb.n_errors++;
        end
        $display("checks %0d errors %0d accepted %0d completed %0d",
            sb.n_checks, sb.n_errors, sb.n_acc, sb.n_done);
        if (sb.n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge clk_g) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, the cache stopped responding", cycles);
            $display("Test failed");
            $finish;
        end
    end

endmodule

//--- tests/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk (
    input logic              clk_g,
    input logic              resetn,
    input logic              req,
    input logic              addr_ok,
    input logic              data_ok,
    input logic              rd_req,
    input dcache_pkg::addr_t rd_addr,
    input logic              rd_rdy,
    input logic              wr_req,
    input dcache_pkg::addr_t wr_addr,
    input logic              wr_rdy
);

    // accepted requests still waiting for data_ok
    int pending;

    always @(posedge clk_g) begin
        if (!resetn) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(req && addr_ok) - int'(data_ok);
        end
    end

    a_one_port: assert property (@(posedge clk_g) disable iff (!resetn)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high together");

    a_rd_hold: assert property (@(posedge clk_g) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else $error("read request dropped or changed before rd_rdy");

    a_wr_hold: assert property (@(posedge clk_g) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
        else $error("write request dropped or changed before wr_rdy");

    a_no_spurious: assert property (@(posedge clk_g) disable iff (!resetn)
        data_ok |-> pending > 0)
        else $error("data_ok without an outstanding request");

endmodule

//--- tests/dcache_scoreboard.sv
`timescale 1ns/1ps

module dcache_scoreboard (
    input logic              clk_g,
    input logic              resetn,
    input logic              req,
    input logic              wr,
    input dcache_pkg::addr_t addr,
    input dcache_pkg::strb_t wstrb,
    input dcache_pkg::word_t wdata,
    input logic              addr_ok,
    input logic              data_ok,
    input dcache_pkg::word_t rdata,
    input logic              rd_req,
    input logic              rd_rdy,
    input logic              wr_req,
    input logic              wr_rdy,
    input dcache_pkg::addr_t wr_addr,
    input dcache_pkg::line_t wr_data
);

    // flat model, missing words still hold the power-up pattern
    logic [31:0] model [logic [29:0]];
    // lines stored to since their last fill
    bit          dirty [logic [27:0]];
    // in-flight requests in acceptance order
    bit          q_wr [$];
    logic [31:0] q_addr [$];
    logic [31:0] q_exp [$];

    string test_name = "reset";
    int    n_checks  = 0;
    int    n_errors  = 0;
    int    n_acc     = 0;
    int    n_done    = 0;
    int    n_refill  = 0;
    bit    rst_seen  = 0;

    function automatic logic [31:0] model_word(input logic [29:0] wa);
        return model.exists(wa) ? model[wa] : ({2'b00, wa} ^ 32'h5a5a_0000);
    endfunction

    always @(posedge clk_g) begin
        logic [31:0]  w;
        logic [127:0] exp_line;
        bit           was_wr;
        logic [31:0]  a;
        logic [31:0]  e;
        if (!resetn) begin
            rst_seen <= 1'b1;
        end else begin
            // completion first, it belongs to an older request
            if (data_ok) begin
                if (q_wr.size() == 0) begin
                    $display("[FAIL] %s: data_ok with no request in flight", test_name);
                    n_errors++;
                end else begin
                    was_wr = q_wr.pop_front();
                    a      = q_addr.pop_front();
                    e      = q_exp.pop_front();
                    n_done++;
                    if (was_wr) begin
                        dirty[a[31:4]] = 1'b1;
                    end else begin
                        n_checks++;
                        if (rdata !== e) begin
                            $display("[FAIL] %s: load %h expected %h actual %h",
                                test_name, a, e, rdata);
                            n_errors++;
                        end
                    end
                end
            end
            if (req && addr_ok) begin
                w = model_word(addr[31:2]);
                if (wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) w[b*8 +: 8] = wdata[b*8 +: 8];
                    end
                    model[addr[31:2]] = w;
                end
                q_wr.push_back(wr);
                q_addr.push_back(addr);
                q_exp.push_back(w);
                n_acc++;
            end
            if (rd_req && rd_rdy) begin
                n_refill++;
            end
            if (wr_req && wr_rdy) begin
                for (int i = 0; i < 4; i++) begin
                    exp_line[i*32 +: 32] = model_word({wr_addr[31:4], 2'(i)});
                end
                n_checks++;
                if (!dirty.exists(wr_addr[31:4])) begin
                    $display("[FAIL] %s: writeback of line %h that was never stored to",
                        test_name, wr_addr);
                    n_errors++;
                end else if (wr_data !== exp_line) begin
                    $display("[FAIL] %s: writeback %h expected %h actual %h",
                        test_name, wr_addr, exp_line, wr_data);
                    n_errors++;
                end
                dirty.delete(wr_addr[31:4]);
            end
        end
    end

    // outputs must sit low while reset holds
    always @(negedge clk_g) begin
        if (!resetn && rst_seen && (data_ok || rd_req || wr_req)) begin
            $display("[FAIL] reset: data_ok, rd_req or wr_req is high during reset");
            n_errors++;
        end
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_g,
    output logic resetn
);

    // 4 ns period
    initial begin
        clk_g = 1'b0;
        forever #2 clk_g = ~clk_g;
    end

    // reset held for 10 cycles
    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk_g);
        resetn <= 1'b1;
    end

endmodule

//--- source/dcache.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache (
    input  logic              clk_g,
    input  logic              resetn,
    // cpu side
    input  logic              req,
    input  logic              wr,
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::strb_t wstrb,
    input  dcache_pkg::word_t wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output dcache_pkg::word_t rdata,
    // memory read
    output logic              rd_req,
    output dcache_pkg::addr_t rd_addr,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  dcache_pkg::line_t ret_data,
    // memory write
    output logic              wr_req,
    output dcache_pkg::addr_t wr_addr,
    output dcache_pkg::line_t wr_data,
    input  logic              wr_rdy,
    input  logic              wr_bvalid
);

    // controller to tag store
    dcache_pkg::index_t    index;
    dcache_pkg::tag_t      tag;
    logic                  touch_en;
    logic                  touch_wr;
    logic                  fill_en;
    logic                  tag_hit;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::way_t      victim_way;
    dcache_pkg::tag_t      victim_tag;
    logic                  victim_dirty;

    // controller to data store
    dcache_pkg::index_t    rd_index;
    dcache_pkg::way_t      rd_way;
    dcache_pkg::line_t     rd_line;
    dcache_pkg::index_t    wr_index;
    logic                  word_en;
    dcache_pkg::way_t      word_way;
    dcache_pkg::word_sel_t word_sel;
    dcache_pkg::strb_t     word_strb;
    dcache_pkg::word_t     word_data;

    dcache_ctrl u_ctrl (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .req          (req),
        .wr           (wr),
        .addr         (addr),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_rdy       (wr_rdy),
        .wr_bvalid    (wr_bvalid),
        .index        (index),
        .tag          (tag),
        .touch_en     (touch_en),
        .touch_wr     (touch_wr),
        .fill_en      (fill_en),
        .tag_hit      (tag_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .rd_index     (rd_index),
        .rd_way       (rd_way),
        .rd_line      (rd_line),
        .wr_index     (wr_index),
        .word_en      (word_en),
        .word_way     (word_way),
        .word_sel     (word_sel),
        .word_strb    (word_strb),
        .word_data    (word_data)
    );

    dcache_tag_store u_tags (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .index        (index),
        .tag          (tag),
        .touch_en     (touch_en),
        .touch_wr     (touch_wr),
        .fill_en      (fill_en),
        .hit          (tag_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    // refill goes into the victim way straight from the memory return
    dcache_data_store u_data (
        .clk_g        (clk_g),
        .rd_index     (rd_index),
        .rd_way       (rd_way),
        .rd_line      (rd_line),
        .wr_index     (wr_index),
        .fill_en      (fill_en),
        .fill_way     (victim_way),
        .fill_line    (ret_data),
        .word_en      (word_en),
        .word_way     (word_way),
        .word_sel     (word_sel),
        .word_strb    (word_strb),
        .word_data    (word_data)
    );

endmodule

//--- source/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                  clk_g,
    input  logic                  resetn,
    // cpu load/store port
    input  logic                  req,
    input  logic                  wr,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::strb_t     wstrb,
    input  dcache_pkg::word_t     wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output dcache_pkg::word_t     rdata,
    // line read from memory
    output logic                  rd_req,
    output dcache_pkg::addr_t     rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    // line writeback to memory
    output logic                  wr_req,
    output dcache_pkg::addr_t     wr_addr,
    output dcache_pkg::line_t     wr_data,
    input  logic                  wr_rdy,
    input  logic                  wr_bvalid,
    // tag store
    output dcache_pkg::index_t    index,
    output dcache_pkg::tag_t      tag,
    output logic                  touch_en,
    output logic                  touch_wr,
    output logic                  fill_en,
    input  logic                  tag_hit,
    input  dcache_pkg::way_t      hit_way,
    input  dcache_pkg::way_t      victim_way,
    input  dcache_pkg::tag_t      victim_tag,
    input  logic                  victim_dirty,
    // data store
    output dcache_pkg::index_t    rd_index,
    output dcache_pkg::way_t      rd_way,
    input  dcache_pkg::line_t     rd_line,
    output dcache_pkg::index_t    wr_index,
    output logic                  word_en,
    output dcache_pkg::way_t      word_way,
    output dcache_pkg::word_sel_t word_sel,
    output dcache_pkg::strb_t     word_strb,
    output dcache_pkg::word_t     word_data
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_nxt;

    // request buffer, one request in lookup
    logic                  req_v;
    logic                  req_wr;
    dcache_pkg::addr_t     req_addr;
    dcache_pkg::strb_t     req_strb;
    dcache_pkg::word_t     req_wdata;
    dcache_pkg::word_sel_t req_word;

    // store stage, merged word on its way into the data store
    logic                  st_v;
    dcache_pkg::addr_t     st_addr;
    dcache_pkg::way_t      st_way;
    dcache_pkg::strb_t     st_strb;
    dcache_pkg::word_t     st_data;

    // last cycle's store stage
    // landed after the read of the request now in lookup was issued
    logic                  ls_v;
    dcache_pkg::addr_t     ls_addr;
    dcache_pkg::word_t     ls_data;

    logic                  accept;
    logic                  lookup_hit;
    dcache_pkg::word_t     line_word;
    dcache_pkg::word_t     fwd_word;
    dcache_pkg::word_t     merged;

    assign index    = req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign tag      = req_addr[31 -: `DCACHE_TAG_W];
    assign req_word = req_addr[`DCACHE_OFFSET_W-1:2];

    // cpu handshake
    assign lookup_hit = (state == dcache_pkg::LOOKUP) && req_v && tag_hit;
    // free slot, or the current one completes this cycle
    assign addr_ok    = (state == dcache_pkg::LOOKUP) && (!req_v || tag_hit);
    assign accept     = req && addr_ok;
    assign data_ok    = lookup_hit;

    // read issued with the new address on acceptance
    // otherwise with the buffered one, for victim read and reread
    assign rd_index = accept ? addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W] : index;
    assign rd_way   = (state == dcache_pkg::LOOKUP) ? hit_way : victim_way;

    assign line_word = rd_line[req_word * `DCACHE_WORD_W +: `DCACHE_WORD_W];

    // forwarding, newest store first
    always_comb begin
        if (st_v && st_addr[31:2] == req_addr[31:2]) begin
            fwd_word = st_data;
        end else if (ls_v && ls_addr[31:2] == req_addr[31:2]) begin
            fwd_word = ls_data;
        end else begin
            fwd_word = line_word;
        end
        // store bytes over the current word
        for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
            merged[b * 8 +: 8] = req_strb[b] ? req_wdata[b * 8 +: 8] : fwd_word[b * 8 +: 8];
        end
    end

    assign rdata = fwd_word;

    // lru and dirty on a completed hit
    assign touch_en = lookup_hit;
    assign touch_wr = req_wr;
    assign fill_en  = (state == dcache_pkg::REFILL) && ret_valid;

    // store stage write, one cycle after lookup
    assign word_en   = st_v;
    assign word_way  = st_way;
    assign word_sel  = st_addr[`DCACHE_OFFSET_W-1:2];
    assign word_strb = st_strb;
    assign word_data = st_data;
    assign wr_index  = fill_en ? index : st_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    // memory handshakes, held by the state until ready
    assign rd_req  = (state == dcache_pkg::MISS_CLEAN);
    assign rd_addr = {req_addr[31:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
    assign wr_req  = (state == dcache_pkg::WB_REQ);
    assign wr_addr = {victim_tag, index, {`DCACHE_OFFSET_W{1'b0}}};
    // victim line, reread every cycle at the same set
    assign wr_data = rd_line;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= dcache_pkg::LOOKUP;
            req_v <= 1'b0;
            st_v  <= 1'b0;
            ls_v  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                req_v <= 1'b1;
            end else if (data_ok) begin
                req_v <= 1'b0;
            end
            st_v <= lookup_hit && req_wr;
            ls_v <= st_v;
        end
    end

    // payload
    always_ff @(posedge clk_g) begin
        if (accept) begin
            req_wr    <= wr;
            req_addr  <= addr;
            req_strb  <= wstrb;
            req_wdata <= wdata;
        end
        st_addr <= req_addr;
        st_way  <= hit_way;
        st_strb <= req_strb;
        st_data <= merged;
        ls_addr <= st_addr;
        ls_data <= st_data;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::LOOKUP: begin
                if (req_v && !tag_hit) begin
                    state_nxt = victim_dirty ? dcache_pkg::MISS_DIRTY : dcache_pkg::MISS_CLEAN;
                end
            end
            // victim read, pending store has landed
            dcache_pkg::MISS_DIRTY: state_nxt = dcache_pkg::WB_REQ;
            dcache_pkg::WB_REQ: begin
                if (wr_rdy) begin
                    state_nxt = dcache_pkg::WB_WAIT;
                end
            end
            dcache_pkg::WB_WAIT: begin
                if (wr_bvalid) begin
                    state_nxt = dcache_pkg::MISS_CLEAN;
                end
            end
            dcache_pkg::MISS_CLEAN: begin
                if (rd_rdy) begin
                    state_nxt = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (ret_valid) begin
                    state_nxt = dcache_pkg::REFILL_DONE;
                end
            end
            // reread of the new line, then lookup hits
            dcache_pkg::REFILL_DONE: state_nxt = dcache_pkg::LOOKUP;
            default: state_nxt = dcache_pkg::LOOKUP;
        endcase
    end

endmodule

//--- source/dcache_data_store.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_data_store (
    input  logic                  clk_g,
    // read port
    input  dcache_pkg::index_t    rd_index,
    input  dcache_pkg::way_t      rd_way,
    output dcache_pkg::line_t     rd_line,
    // write port, shared set number
    input  dcache_pkg::index_t    wr_index,
    input  logic                  fill_en,
    input  dcache_pkg::way_t      fill_way,
    input  dcache_pkg::line_t     fill_line,
    input  logic                  word_en,
    input  dcache_pkg::way_t      word_way,
    input  dcache_pkg::word_sel_t word_sel,
    input  dcache_pkg::strb_t     word_strb,
    input  dcache_pkg::word_t     word_data
);

    dcache_pkg::line_t mem  [`DCACHE_WAYS][`DCACHE_SETS];
    // both ways read each cycle
    dcache_pkg::line_t rd_q [`DCACHE_WAYS];

    // read sees the value from before a same-cycle write
    always_ff @(posedge clk_g) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            rd_q[w] <= mem[w][rd_index];
        end
    end

    // way picked after the read, once the tag compare is done
    assign rd_line = rd_q[rd_way];

    always_ff @(posedge clk_g) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (fill_en && fill_way == dcache_pkg::way_t'(w)) begin
                // refill replaces the whole line
                mem[w][wr_index] <= fill_line;
            end else if (word_en && word_way == dcache_pkg::way_t'(w)) begin
                for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
                    if (word_strb[b]) begin
                        mem[w][wr_index][word_sel * `DCACHE_WORD_W + b * 8 +: 8] <=
                            word_data[b * 8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- source/dcache_tag_store.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_store (
    input  logic               clk_g,
    input  logic               resetn,
    // set and tag of the buffered request
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    // update strobes
    input  logic               touch_en,
    input  logic               touch_wr,
    input  logic               fill_en,
    // lookup result, combinational
    output logic               hit,
    output dcache_pkg::way_t   hit_way,
    output dcache_pkg::way_t   victim_way,
    output dcache_pkg::tag_t   victim_tag,
    output logic               victim_dirty
);

    // per set, one bit per way
    logic [`DCACHE_WAYS-1:0] valid_q [`DCACHE_SETS];
    logic [`DCACHE_WAYS-1:0] dirty_q [`DCACHE_SETS];
    // lru bit holds the way to evict next
    logic [`DCACHE_SETS-1:0] lru_q;
    dcache_pkg::tag_t        tag_q [`DCACHE_WAYS][`DCACHE_SETS];

    logic [`DCACHE_WAYS-1:0] way_hit;

    // compare both ways at once
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = valid_q[index][w] && (tag_q[w][index] == tag);
        end
    end

    assign hit          = |way_hit;
    // two ways only, so way 1 hit gives the number directly
    assign hit_way      = way_hit[1];
    assign victim_way   = lru_q[index];
    assign victim_tag   = tag_q[victim_way][index];
    // dirty is only ever set on a valid line
    assign victim_dirty = dirty_q[index][victim_way];

    // control bits
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else if (fill_en) begin
            // new line comes in clean
            valid_q[index][victim_way] <= 1'b1;
            dirty_q[index][victim_way] <= 1'b0;
            lru_q[index]               <= ~victim_way;
        end else if (touch_en) begin
            // other way becomes the victim
            lru_q[index] <= ~hit_way;
            if (touch_wr) begin
                dirty_q[index][hit_way] <= 1'b1;
            end
        end
    end

    // tags, written only by a refill
    always_ff @(posedge clk_g) begin
        if (fill_en) begin
            tag_q[victim_way][index] <= tag;
        end
    end

endmodule

//--- source/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    // cpu byte address
    typedef logic [31:0]                     addr_t;
    typedef logic [`DCACHE_WORD_W-1:0]       word_t;
    // one whole line, word 0 in the low bits
    typedef logic [`DCACHE_LINE_W-1:0]       line_t;
    typedef logic [`DCACHE_TAG_W-1:0]        tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]      index_t;
    // word number inside a line
    typedef logic [`DCACHE_OFFSET_W-3:0]     word_sel_t;
    // one strobe per byte of a word
    typedef logic [`DCACHE_WORD_W/8-1:0]     strb_t;
    typedef logic                            way_t;

    // miss handling FSM
    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WB_REQ,
        WB_WAIT,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } ctrl_state_t;

endpackage

//--- source/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DCACHE_WAYS       2
`define DCACHE_SETS       16
`define DCACHE_LINE_WORDS 4

// data widths
`define DCACHE_WORD_W     32
`define DCACHE_LINE_W     128

// address split, tag | index | byte offset
`define DCACHE_INDEX_W    4
// byte offset inside one line
`define DCACHE_OFFSET_W   4
`define DCACHE_TAG_W      24

`endif
